// File: src.f
+incdir+.
memsys_pkg.sv
data_ram.sv
stage_memory1.sv
stage_memory2.sv
mem_backend_top.sv
tb_mem_backend.sv

// File: Bender.yml
package:
  name: mem_backend

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - memsys_pkg.sv
      - data_ram.sv
      - stage_memory1.sv
      - stage_memory2.sv
      - mem_backend_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_mem_backend.sv

// File: tb_mem_backend.sv
`timescale 1ns/10ps

`include "memsys_settings.svh"

module tb_mem_backend
    import memsys_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int SEED       = 26313;
    localparam int N_INIT     = 16; // Word stores that fill the test region
    localparam int N_ALU      = 12;
    localparam int N_MEM      = 40; // Store, same-word load, random load
    localparam int N_FLUSH    = 4;
    localparam int N_STALL    = 6;
    localparam int PLANNED_CYCLES = 16 + N_INIT + N_ALU + 3 * N_MEM + 5 * N_FLUSH
                                  + 5 * N_STALL + 4;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        flush;
    logic        e_valid;
    logic [31:0] e_pc;
    logic [31:0] e_alu_result;
    logic [31:0] e_rs2_val;
    logic [4:0]  e_rd_idx;
    logic        e_rd_we;
    rd_src_e     e_rd_src;
    mem_op_e     e_mem_op;
    mem_size_e   e_mem_size;
    logic        e_mem_signed;
    logic        e_branch_taken;
    logic [31:0] e_branch_target;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic        fwd_m1_produces_rd;
    logic [4:0]  fwd_m1_rd_idx;
    logic        fwd_m1_val_avail;
    logic [31:0] fwd_m1_val;
    logic        fwd_m2_produces_rd;
    logic [4:0]  fwd_m2_rd_idx;
    logic        fwd_m2_val_avail;
    logic [31:0] fwd_m2_val;
    logic        wb_valid;
    logic [4:0]  wb_rd_idx;
    logic        wb_rd_we;
    logic [31:0] wb_rd_val;

    // Expected pipeline, one slot per stage
    logic        exp_m1_v;
    logic [31:0] exp_m1_pc;
    logic [31:0] exp_m1_alu;
    logic [31:0] exp_m1_rs2;
    logic [4:0]  exp_m1_idx;
    logic        exp_m1_we;
    rd_src_e     exp_m1_src;
    mem_op_e     exp_m1_op;
    mem_size_e   exp_m1_size;
    logic        exp_m1_sgn;
    logic        exp_m1_br;
    logic [31:0] exp_m1_brt;
    logic        exp_m2_v;
    logic [4:0]  exp_m2_idx;
    logic        exp_m2_we;
    logic [31:0] exp_m2_val;

    logic        exp_wb_valid;
    logic        exp_branch;
    logic        exp_m1_prod;
    logic        exp_m1_avail;
    logic [31:0] exp_m1_val;
    logic        exp_m2_prod;

    logic [7:0]  ref_mem [0:1023]; // Byte image of the data RAM
    int          errors;
    int          wb_count;

    mem_backend_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] load_value(input logic [31:0] addr, input mem_size_e size,
                                               input logic sgn);
        logic [9:0]  base;
        logic [31:0] word;
        base = addr[9:0];
        word = {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
        case (size)
            MEM_SIZE_BYTE: return {{24{sgn & word[7]}}, word[7:0]};
            MEM_SIZE_HALF: return {{16{sgn & word[15]}}, word[15:0]};
            default:       return word;
        endcase
    endfunction

    task automatic store_ref(input logic [31:0] addr, input mem_size_e size,
                             input logic [31:0] data);
        int nbytes;
        nbytes = (size == MEM_SIZE_BYTE) ? 1 : (size == MEM_SIZE_HALF) ? 2 : 4;
        for (int i = 0; i < nbytes; i++) begin
            ref_mem[addr[9:0] + i] = data[i*8 +: 8];
        end
    endtask

    // Model advances only on unstalled edges, flush drops the Memory 1 slot
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_m1_v <= 1'b0;
            exp_m2_v <= 1'b0;
        end else if (!stall) begin
            exp_m1_v    <= e_valid;
            exp_m1_pc   <= e_pc;
            exp_m1_alu  <= e_alu_result;
            exp_m1_rs2  <= e_rs2_val;
            exp_m1_idx  <= e_rd_idx;
            exp_m1_we   <= e_rd_we;
            exp_m1_src  <= e_rd_src;
            exp_m1_op   <= e_mem_op;
            exp_m1_size <= e_mem_size;
            exp_m1_sgn  <= e_mem_signed;
            exp_m1_br   <= e_branch_taken;
            exp_m1_brt  <= e_branch_target;
            exp_m2_v    <= exp_m1_v && !flush;
            exp_m2_idx  <= exp_m1_idx;
            exp_m2_we   <= exp_m1_we;
            exp_m2_val  <= (exp_m1_src == RD_SRC_MEM)
                         ? load_value(exp_m1_alu, exp_m1_size, exp_m1_sgn) : exp_m1_val;
            if (exp_m1_v && !flush && (exp_m1_op == MEM_OP_STORE)) begin
                store_ref(exp_m1_alu, exp_m1_size, exp_m1_rs2);
            end
        end else if (flush) begin
            exp_m1_v <= 1'b0;
        end
    end

    assign exp_wb_valid = exp_m2_v && !stall;
    assign exp_branch   = exp_m1_v && exp_m1_br;
    assign exp_m1_prod  = exp_m1_v && exp_m1_we;
    assign exp_m1_avail = exp_m1_prod && (exp_m1_src != RD_SRC_MEM); // Load value unknown yet
    assign exp_m1_val   = (exp_m1_src == RD_SRC_PC4) ? exp_m1_pc + 32'd4 : exp_m1_alu;
    assign exp_m2_prod  = exp_m2_v && exp_m2_we;

    always @(posedge clk) begin
        if (rst_n && wb_valid) begin
            wb_count++;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
    endtask

    a_wb_valid: assert property (@(posedge clk) disable iff (!rst_n) wb_valid == exp_wb_valid)
        else report_mismatch("wb_valid", $sampled(exp_wb_valid), $sampled(wb_valid));
    a_wb_val: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_rd_val == exp_m2_val)
        else report_mismatch("wb_rd_val", $sampled(exp_m2_val), $sampled(wb_rd_val));
    a_wb_dest: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> {wb_rd_we, wb_rd_idx} == {exp_m2_we, exp_m2_idx})
        else report_mismatch("{wb_rd_we, wb_rd_idx}", $sampled({exp_m2_we, exp_m2_idx}),
                             $sampled({wb_rd_we, wb_rd_idx}));
    a_branch: assert property (@(posedge clk) disable iff (!rst_n) branch_taken == exp_branch)
        else report_mismatch("branch_taken", $sampled(exp_branch), $sampled(branch_taken));
    a_branch_target: assert property (@(posedge clk) disable iff (!rst_n)
        branch_taken |-> branch_target == exp_m1_brt)
        else report_mismatch("branch_target", $sampled(exp_m1_brt), $sampled(branch_target));
    a_m1_prod: assert property (@(posedge clk) disable iff (!rst_n)
        {fwd_m1_produces_rd, fwd_m1_val_avail} == {exp_m1_prod, exp_m1_avail})
        else report_mismatch("{fwd_m1_produces_rd, fwd_m1_val_avail}",
                             $sampled({exp_m1_prod, exp_m1_avail}),
                             $sampled({fwd_m1_produces_rd, fwd_m1_val_avail}));
    a_m1_idx: assert property (@(posedge clk) disable iff (!rst_n)
        fwd_m1_produces_rd |-> fwd_m1_rd_idx == exp_m1_idx)
        else report_mismatch("fwd_m1_rd_idx", $sampled(exp_m1_idx), $sampled(fwd_m1_rd_idx));
    a_m1_val: assert property (@(posedge clk) disable iff (!rst_n)
        fwd_m1_val_avail |-> fwd_m1_val == exp_m1_val)
        else report_mismatch("fwd_m1_val", $sampled(exp_m1_val), $sampled(fwd_m1_val));
    a_m2_prod: assert property (@(posedge clk) disable iff (!rst_n)
        {fwd_m2_produces_rd, fwd_m2_val_avail} == {exp_m2_prod, exp_m2_prod})
        else report_mismatch("{fwd_m2_produces_rd, fwd_m2_val_avail}",
                             $sampled({exp_m2_prod, exp_m2_prod}),
                             $sampled({fwd_m2_produces_rd, fwd_m2_val_avail}));
    a_m2_idx: assert property (@(posedge clk) disable iff (!rst_n)
        fwd_m2_produces_rd |-> fwd_m2_rd_idx == exp_m2_idx)
        else report_mismatch("fwd_m2_rd_idx", $sampled(exp_m2_idx), $sampled(fwd_m2_rd_idx));
    a_m2_val: assert property (@(posedge clk) disable iff (!rst_n)
        fwd_m2_val_avail |-> fwd_m2_val == exp_m2_val)
        else report_mismatch("fwd_m2_val", $sampled(exp_m2_val), $sampled(fwd_m2_val));

    function automatic logic [31:0] align(input logic [31:0] addr, input mem_size_e size);
        case (size)
            MEM_SIZE_HALF: return {addr[31:1], 1'b0};
            MEM_SIZE_WORD: return {addr[31:2], 2'b00};
            default:       return addr;
        endcase
    endfunction

    // Upper bits are random, the RAM only sees bits 9:2
    function automatic logic [31:0] random_addr(input mem_size_e size);
        return align(($urandom & 32'hFFFF_FC00) | ($urandom % 64), size);
    endfunction

    // One execute item on the inputs, stall and flush released
    task automatic drive_item(input logic valid, input mem_op_e op, input rd_src_e src,
                              input mem_size_e size, input logic sgn, input logic [31:0] alu,
                              input logic [31:0] rs2, input logic br);
        logic [31:0] rnd;
        rnd             = $urandom;
        stall           = 1'b0;
        flush           = 1'b0;
        e_valid         = valid;
        e_pc            = $urandom & 32'hFFFF_FFFC;
        e_alu_result    = alu;
        e_rs2_val       = rs2;
        e_rd_idx        = rnd[4:0];
        e_rd_we         = (op != MEM_OP_STORE);
        e_rd_src        = src;
        e_mem_op        = op;
        e_mem_size      = size;
        e_mem_signed    = sgn;
        e_branch_taken  = br;
        e_branch_target = $urandom & 32'hFFFF_FFFC;
    endtask

    task automatic issue(input logic valid, input mem_op_e op, input rd_src_e src,
                         input mem_size_e size, input logic sgn, input logic [31:0] alu,
                         input logic [31:0] rs2, input logic br);
        @(negedge clk);
        drive_item(valid, op, src, size, sgn, alu, rs2, br);
    endtask

    task automatic store(input logic [31:0] addr, input mem_size_e size, input logic [31:0] data);
        issue(1'b1, MEM_OP_STORE, RD_SRC_ALU, size, 1'b0, addr, data, 1'b0);
    endtask

    task automatic load(input logic [31:0] addr, input mem_size_e size, input logic sgn);
        issue(1'b1, MEM_OP_LOAD, RD_SRC_MEM, size, sgn, addr, $urandom, 1'b0);
    endtask

    task automatic compute_item(input rd_src_e src, input logic br);
        issue(1'b1, MEM_OP_NONE, src, MEM_SIZE_WORD, 1'b0, $urandom, $urandom, br);
    endtask

    task automatic flush_cycle();
        @(negedge clk);
        e_valid = 1'b0;
        flush   = 1'b1; // Kills whatever sits in Memory 1
    endtask

    // Execute side keeps changing, nothing may be captured
    task automatic stall_for(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            stall        = 1'b1;
            e_valid      = $urandom_range(0, 1);
            e_alu_result = $urandom;
        end
    endtask

    initial begin
        mem_size_e   size;
        logic [31:0] addr;
        void'($urandom(SEED));
        errors   = 0;
        wb_count = 0;
        rst_n    = 1'b0;
        drive_item(1'b0, MEM_OP_NONE, RD_SRC_ALU, MEM_SIZE_WORD, 1'b0, 32'd0, 32'd0, 1'b0);
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        for (int w = 0; w < N_INIT; w++) begin
            store(w * 4, MEM_SIZE_WORD, $urandom);
        end
        for (int i = 0; i < N_ALU; i++) begin
            compute_item((i % 2) ? RD_SRC_PC4 : RD_SRC_ALU, $urandom_range(0, 1));
        end
        for (int i = 0; i < N_MEM; i++) begin
            size = mem_size_e'($urandom_range(0, 2));
            addr = random_addr(size);
            store(addr, size, $urandom);
            size = mem_size_e'($urandom_range(0, 2));
            load(align({addr[31:2], 2'($urandom)}, size), size, $urandom_range(0, 1)); // Same word
            size = mem_size_e'($urandom_range(0, 2));
            load(random_addr(size), size, $urandom_range(0, 1));
        end
        for (int i = 0; i < N_FLUSH; i++) begin
            addr = random_addr(MEM_SIZE_WORD);
            store(addr, MEM_SIZE_WORD, $urandom);
            flush_cycle();
            compute_item(RD_SRC_ALU, 1'b0);
            flush_cycle();
            load(addr, MEM_SIZE_WORD, 1'b0); // Still the old word
        end
        for (int i = 0; i < N_STALL; i++) begin
            compute_item(RD_SRC_PC4, 1'b0);
            size = mem_size_e'($urandom_range(0, 2));
            load(random_addr(size), size, 1'b1);
            stall_for($urandom_range(1, 3));
        end
        repeat (4) begin
            issue(1'b0, MEM_OP_NONE, RD_SRC_ALU, MEM_SIZE_WORD, 1'b0, 32'd0, 32'd0, 1'b0);
        end
        if (wb_count == 0) begin
            errors++;
            $display("No writeback was seen during the whole run");
        end
        $display("Writebacks: %0d, errors: %0d", wb_count, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(2 * PLANNED_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, stimulus did not finish", 2 * PLANNED_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule : tb_mem_backend

// File: mem_backend_top.sv
`timescale 1ns/10ps

`include "memsys_settings.svh"

module mem_backend_top
    import memsys_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            stall,
    input  logic                            flush,

    input  logic                            e_valid,
    input  logic [`MEMSYS_XLEN-1:0]         e_pc,
    input  logic [`MEMSYS_XLEN-1:0]         e_alu_result,
    input  logic [`MEMSYS_XLEN-1:0]         e_rs2_val,
    input  logic [`MEMSYS_REG_IDX_BITS-1:0] e_rd_idx,
    input  logic                            e_rd_we,
    input  rd_src_e                         e_rd_src,
    input  mem_op_e                         e_mem_op,
    input  mem_size_e                       e_mem_size,
    input  logic                            e_mem_signed,
    input  logic                            e_branch_taken,
    input  logic [`MEMSYS_XLEN-1:0]         e_branch_target,

    output logic                            branch_taken,
    output logic [`MEMSYS_XLEN-1:0]         branch_target,

    output logic                            fwd_m1_produces_rd,
    output logic [`MEMSYS_REG_IDX_BITS-1:0] fwd_m1_rd_idx,
    output logic                            fwd_m1_val_avail,
    output logic [`MEMSYS_XLEN-1:0]         fwd_m1_val,

    output logic                            fwd_m2_produces_rd,
    output logic [`MEMSYS_REG_IDX_BITS-1:0] fwd_m2_rd_idx,
    output logic                            fwd_m2_val_avail,
    output logic [`MEMSYS_XLEN-1:0]         fwd_m2_val,

    output logic                            wb_valid,
    output logic [`MEMSYS_REG_IDX_BITS-1:0] wb_rd_idx,
    output logic                            wb_rd_we,
    output logic [`MEMSYS_XLEN-1:0]         wb_rd_val
);

    // Memory 1 to RAM
    logic                              ram_rd_en;
    logic [`MEMSYS_DMEM_ADDR_BITS-1:0] ram_rd_addr;
    logic [`MEMSYS_XLEN-1:0]           ram_rd_data;
    logic                              ram_wr_en;
    logic [3:0]                        ram_wr_strb;
    logic [`MEMSYS_DMEM_ADDR_BITS-1:0] ram_wr_addr;
    logic [`MEMSYS_XLEN-1:0]           ram_wr_data;

    // Memory 1 to Memory 2
    logic                              m1_to_m2_valid;
    logic [`MEMSYS_XLEN-1:0]           m1_to_m2_pc;
    logic [`MEMSYS_XLEN-1:0]           m1_to_m2_alu_result;
    logic [`MEMSYS_REG_IDX_BITS-1:0]   m1_to_m2_rd_idx;
    logic                              m1_to_m2_rd_we;
    rd_src_e                           m1_to_m2_rd_src;
    mem_op_e                           m1_to_m2_mem_op;
    mem_size_e                         m1_to_m2_mem_size;
    logic                              m1_to_m2_mem_signed;
    logic [1:0]                        m1_to_m2_addr_lo;

    stage_memory1 m1_i (
        .clk, .rst_n, .stall, .flush,
        .e_valid, .e_pc, .e_alu_result, .e_rs2_val, .e_rd_idx, .e_rd_we, .e_rd_src,
        .e_mem_op, .e_mem_size, .e_mem_signed, .e_branch_taken, .e_branch_target,
        .branch_taken, .branch_target,
        .ram_rd_en, .ram_rd_addr, .ram_wr_en, .ram_wr_strb, .ram_wr_addr, .ram_wr_data,
        .fwd_m1_produces_rd, .fwd_m1_rd_idx, .fwd_m1_val_avail, .fwd_m1_val,
        .m1_to_m2_valid, .m1_to_m2_pc, .m1_to_m2_alu_result, .m1_to_m2_rd_idx,
        .m1_to_m2_rd_we, .m1_to_m2_rd_src, .m1_to_m2_mem_op, .m1_to_m2_mem_size,
        .m1_to_m2_mem_signed, .m1_to_m2_addr_lo
    );

    data_ram ram_i (
        .clk,
        .rd_en   (ram_rd_en),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data),
        .wr_en   (ram_wr_en),
        .wr_strb (ram_wr_strb),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_wr_data)
    );

    stage_memory2 m2_i (
        .clk, .rst_n, .stall,
        .m1_to_m2_valid, .m1_to_m2_pc, .m1_to_m2_alu_result, .m1_to_m2_rd_idx,
        .m1_to_m2_rd_we, .m1_to_m2_rd_src, .m1_to_m2_mem_op, .m1_to_m2_mem_size,
        .m1_to_m2_mem_signed, .m1_to_m2_addr_lo,
        .ram_rd_data,
        .fwd_m2_produces_rd, .fwd_m2_rd_idx, .fwd_m2_val_avail, .fwd_m2_val,
        .wb_valid, .wb_rd_idx, .wb_rd_we, .wb_rd_val
    );

endmodule : mem_backend_top

// File: stage_memory2.sv
`timescale 1ns/10ps

`include "memsys_settings.svh"

module stage_memory2
    import memsys_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            stall,

    input  logic                            m1_to_m2_valid,
    input  logic [`MEMSYS_XLEN-1:0]         m1_to_m2_pc,
    input  logic [`MEMSYS_XLEN-1:0]         m1_to_m2_alu_result,
    input  logic [`MEMSYS_REG_IDX_BITS-1:0] m1_to_m2_rd_idx,
    input  logic                            m1_to_m2_rd_we,
    input  rd_src_e                         m1_to_m2_rd_src,
    input  mem_op_e                         m1_to_m2_mem_op,
    input  mem_size_e                       m1_to_m2_mem_size,
    input  logic                            m1_to_m2_mem_signed,
    input  logic [1:0]                      m1_to_m2_addr_lo,

    input  logic [`MEMSYS_XLEN-1:0]         ram_rd_data,

    output logic                            fwd_m2_produces_rd,
    output logic [`MEMSYS_REG_IDX_BITS-1:0] fwd_m2_rd_idx,
    output logic                            fwd_m2_val_avail,
    output logic [`MEMSYS_XLEN-1:0]         fwd_m2_val,

    output logic                            wb_valid,
    output logic [`MEMSYS_REG_IDX_BITS-1:0] wb_rd_idx,
    output logic                            wb_rd_we,
    output logic [`MEMSYS_XLEN-1:0]         wb_rd_val
);

    logic                            ff_valid;
    logic [`MEMSYS_XLEN-1:0]         ff_pc;
    logic [`MEMSYS_XLEN-1:0]         ff_alu_result;
    logic [`MEMSYS_REG_IDX_BITS-1:0] ff_rd_idx;
    logic                            ff_rd_we;
    rd_src_e                         ff_rd_src;
    mem_op_e                         ff_mem_op;
    mem_size_e                       ff_mem_size;
    logic                            ff_mem_signed;
    logic [1:0]                      ff_addr_lo;
    logic [`MEMSYS_XLEN-1:0]         ff_ram_data;

    logic [7:0]                      load_byte;
    logic [15:0]                     load_half;
    logic [`MEMSYS_XLEN-1:0]         load_val;
    logic [`MEMSYS_XLEN-1:0]         rd_val;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_valid <= 1'b0;
        end else if (!stall) begin
            ff_valid <= m1_to_m2_valid;
        end
    end

    // RAM word is captured here, the read register moves on to the next load
    always_ff @(posedge clk) begin
        if (!stall) begin
            ff_pc         <= m1_to_m2_pc;
            ff_alu_result <= m1_to_m2_alu_result;
            ff_rd_idx     <= m1_to_m2_rd_idx;
            ff_rd_we      <= m1_to_m2_rd_we;
            ff_rd_src     <= m1_to_m2_rd_src;
            ff_mem_op     <= m1_to_m2_mem_op;
            ff_mem_size   <= m1_to_m2_mem_size;
            ff_mem_signed <= m1_to_m2_mem_signed;
            ff_addr_lo    <= m1_to_m2_addr_lo;
            ff_ram_data   <= ram_rd_data;
        end
    end

    assign load_byte = ff_ram_data[ff_addr_lo*8 +: 8];
    assign load_half = ff_addr_lo[1] ? ff_ram_data[31:16] : ff_ram_data[15:0];

    always_comb begin
        unique case (ff_mem_size)
            MEM_SIZE_BYTE: load_val = {{24{ff_mem_signed & load_byte[7]}}, load_byte};
            MEM_SIZE_HALF: load_val = {{16{ff_mem_signed & load_half[15]}}, load_half};
            default:       load_val = ff_ram_data;
        endcase
    end

    always_comb begin
        unique case (ff_rd_src)
            RD_SRC_MEM: rd_val = load_val;
            RD_SRC_PC4: rd_val = ff_pc + 32'd4;
            default:    rd_val = ff_alu_result;
        endcase
    end

    assign wb_valid  = ff_valid && !stall;
    assign wb_rd_idx = ff_rd_idx;
    assign wb_rd_we  = ff_rd_we;
    assign wb_rd_val = rd_val;

    // Every source is resolved by now
    assign fwd_m2_produces_rd = ff_valid && ff_rd_we;
    assign fwd_m2_rd_idx      = ff_rd_idx;
    assign fwd_m2_val_avail   = fwd_m2_produces_rd;
    assign fwd_m2_val         = rd_val;

    // Source must be known, and a memory source only comes from a load
    a_known_src: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> ((ff_rd_src inside {RD_SRC_ALU, RD_SRC_MEM, RD_SRC_PC4})
                      && ((ff_rd_src != RD_SRC_MEM) || (ff_mem_op == MEM_OP_LOAD))))
        else $error("Bad rd_src %0d with mem_op %0d at writeback", ff_rd_src, ff_mem_op);

endmodule : stage_memory2

// File: stage_memory1.sv
`timescale 1ns/10ps

`include "memsys_settings.svh"

module stage_memory1
    import memsys_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              stall,
    input  logic                              flush,

    input  logic                              e_valid,
    input  logic [`MEMSYS_XLEN-1:0]           e_pc,
    input  logic [`MEMSYS_XLEN-1:0]           e_alu_result,
    input  logic [`MEMSYS_XLEN-1:0]           e_rs2_val,
    input  logic [`MEMSYS_REG_IDX_BITS-1:0]   e_rd_idx,
    input  logic                              e_rd_we,
    input  rd_src_e                           e_rd_src,
    input  mem_op_e                           e_mem_op,
    input  mem_size_e                         e_mem_size,
    input  logic                              e_mem_signed,
    input  logic                              e_branch_taken,
    input  logic [`MEMSYS_XLEN-1:0]           e_branch_target,

    output logic                              branch_taken,
    output logic [`MEMSYS_XLEN-1:0]           branch_target,

    output logic                              ram_rd_en,
    output logic [`MEMSYS_DMEM_ADDR_BITS-1:0] ram_rd_addr,
    output logic                              ram_wr_en,
    output logic [3:0]                        ram_wr_strb,
    output logic [`MEMSYS_DMEM_ADDR_BITS-1:0] ram_wr_addr,
    output logic [`MEMSYS_XLEN-1:0]           ram_wr_data,

    output logic                              fwd_m1_produces_rd,
    output logic [`MEMSYS_REG_IDX_BITS-1:0]   fwd_m1_rd_idx,
    output logic                              fwd_m1_val_avail,
    output logic [`MEMSYS_XLEN-1:0]           fwd_m1_val,

    output logic                              m1_to_m2_valid,
    output logic [`MEMSYS_XLEN-1:0]           m1_to_m2_pc,
    output logic [`MEMSYS_XLEN-1:0]           m1_to_m2_alu_result,
    output logic [`MEMSYS_REG_IDX_BITS-1:0]   m1_to_m2_rd_idx,
    output logic                              m1_to_m2_rd_we,
    output rd_src_e                           m1_to_m2_rd_src,
    output mem_op_e                           m1_to_m2_mem_op,
    output mem_size_e                         m1_to_m2_mem_size,
    output logic                              m1_to_m2_mem_signed,
    output logic [1:0]                        m1_to_m2_addr_lo
);

    logic                            ff_valid;
    logic [`MEMSYS_XLEN-1:0]         ff_pc;
    logic [`MEMSYS_XLEN-1:0]         ff_alu_result;
    logic [`MEMSYS_XLEN-1:0]         ff_rs2_val;
    logic [`MEMSYS_REG_IDX_BITS-1:0] ff_rd_idx;
    logic                            ff_rd_we;
    rd_src_e                         ff_rd_src;
    mem_op_e                         ff_mem_op;
    mem_size_e                       ff_mem_size;
    logic                            ff_mem_signed;
    logic                            ff_branch_taken;
    logic [`MEMSYS_XLEN-1:0]         ff_branch_target;

    logic                            out_valid;
    logic                            misaligned;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_valid <= 1'b0;
        end else if (!stall) begin
            ff_valid <= e_valid;
        end else if (flush) begin
            ff_valid <= 1'b0; // Killed item must not come back after the stall
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ff_pc            <= e_pc;
            ff_alu_result    <= e_alu_result;
            ff_rs2_val       <= e_rs2_val;
            ff_rd_idx        <= e_rd_idx;
            ff_rd_we         <= e_rd_we;
            ff_rd_src        <= e_rd_src;
            ff_mem_op        <= e_mem_op;
            ff_mem_size      <= e_mem_size;
            ff_mem_signed    <= e_mem_signed;
            ff_branch_taken  <= e_branch_taken;
            ff_branch_target <= e_branch_target;
        end
    end

    assign out_valid = ff_valid && !flush && !stall;

    assign branch_taken  = ff_valid && ff_branch_taken;
    assign branch_target = ff_branch_target;

    // Load read starts from the unregistered address
    assign ram_rd_en   = !stall;
    assign ram_rd_addr = e_alu_result[`MEMSYS_DMEM_ADDR_BITS+1:2];

    assign ram_wr_en   = out_valid && (ff_mem_op == MEM_OP_STORE);
    assign ram_wr_addr = ff_alu_result[`MEMSYS_DMEM_ADDR_BITS+1:2];

    // Replicate store data into every lane, strobes pick the lanes
    always_comb begin
        unique case (ff_mem_size)
            MEM_SIZE_BYTE: begin
                ram_wr_data = {4{ff_rs2_val[7:0]}};
                ram_wr_strb = 4'b0001 << ff_alu_result[1:0];
            end
            MEM_SIZE_HALF: begin
                ram_wr_data = {2{ff_rs2_val[15:0]}};
                ram_wr_strb = ff_alu_result[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                ram_wr_data = ff_rs2_val;
                ram_wr_strb = 4'b1111;
            end
        endcase
    end

    assign fwd_m1_produces_rd = ff_valid && ff_rd_we;
    assign fwd_m1_rd_idx      = ff_rd_idx;
    assign fwd_m1_val_avail   = fwd_m1_produces_rd && (ff_rd_src != RD_SRC_MEM); // Load data not back yet
    assign fwd_m1_val         = (ff_rd_src == RD_SRC_PC4) ? ff_pc + 32'd4 : ff_alu_result;

    assign m1_to_m2_valid      = out_valid;
    assign m1_to_m2_pc         = ff_pc;
    assign m1_to_m2_alu_result = ff_alu_result;
    assign m1_to_m2_rd_idx     = ff_rd_idx;
    assign m1_to_m2_rd_we      = ff_rd_we;
    assign m1_to_m2_rd_src     = ff_rd_src;
    assign m1_to_m2_mem_op     = ff_mem_op;
    assign m1_to_m2_mem_size   = ff_mem_size;
    assign m1_to_m2_mem_signed = ff_mem_signed;
    assign m1_to_m2_addr_lo    = ff_alu_result[1:0];

    assign misaligned = ((ff_mem_size == MEM_SIZE_HALF) && ff_alu_result[0])
                     || ((ff_mem_size == MEM_SIZE_WORD) && (ff_alu_result[1:0] != 2'b00));

    // Execute must only send naturally aligned accesses
    a_aligned_access: assert property (@(posedge clk) disable iff (!rst_n)
        (ff_valid && (ff_mem_op != MEM_OP_NONE)) |-> !misaligned)
        else $error("Misaligned access at pc %h addr %h", ff_pc, ff_alu_result);

endmodule : stage_memory1

// File: data_ram.sv
`timescale 1ns/10ps

`include "memsys_settings.svh"

module data_ram (
    input  logic                              clk,

    input  logic                              rd_en,
    input  logic [`MEMSYS_DMEM_ADDR_BITS-1:0] rd_addr,
    output logic [`MEMSYS_XLEN-1:0]           rd_data,

    input  logic                              wr_en,
    input  logic [3:0]                        wr_strb,
    input  logic [`MEMSYS_DMEM_ADDR_BITS-1:0] wr_addr,
    input  logic [`MEMSYS_XLEN-1:0]           wr_data
);

    logic [`MEMSYS_XLEN-1:0] mem [0:`MEMSYS_DMEM_WORDS-1];

    logic                    addr_match;
    logic [`MEMSYS_XLEN-1:0] rd_word;
    logic [`MEMSYS_XLEN-1:0] rd_next;

    assign addr_match = wr_en && (wr_addr == rd_addr);
    assign rd_word    = mem[rd_addr];

    // Write-first merge, so a store is visible to a read of the same word
    always_comb begin
        rd_next = rd_word;
        for (int i = 0; i < 4; i++) begin
            if (addr_match && wr_strb[i]) begin
                rd_next[i*8 +: 8] = wr_data[i*8 +: 8];
            end
        end
    end

    // Byte-lane writes
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_addr][i*8 +: 8] <= wr_data[i*8 +: 8];
                end
            end
        end
    end

    // Read register holds while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= rd_next;
        end
    end

endmodule : data_ram

// File: memsys_pkg.sv
package memsys_pkg;

    // Which value goes to rd at writeback
    typedef enum logic [1:0] {
        RD_SRC_ALU = 2'b00, // ALU result
        RD_SRC_MEM = 2'b01, // Loaded data
        RD_SRC_PC4 = 2'b10  // Link address for jumps
    } rd_src_e;

    // Kind of data memory access
    typedef enum logic [1:0] {
        MEM_OP_NONE  = 2'b00,
        MEM_OP_LOAD  = 2'b01,
        MEM_OP_STORE = 2'b10
    } mem_op_e;

    // Access width
    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'b00,
        MEM_SIZE_HALF = 2'b01,
        MEM_SIZE_WORD = 2'b10
    } mem_size_e;

endpackage : memsys_pkg

// File: memsys_settings.svh
`ifndef MEMSYS_SETTINGS_SVH
`define MEMSYS_SETTINGS_SVH

// Data path and address width
`define MEMSYS_XLEN 32

// Register file index width
`define MEMSYS_REG_IDX_BITS 5

// Data RAM geometry, in 32-bit words
`define MEMSYS_DMEM_WORDS 256

// Word address taken from byte address bits 9:2
`define MEMSYS_DMEM_ADDR_BITS 8

`endif
